// File: hdl/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// datapath width
`define OOO_XLEN        32

// register counts
`define OOO_ARCH_REGS   8
`define OOO_PHYS_REGS   16

// queue depths
`define OOO_ROB_DEPTH   8
`define OOO_RS_DEPTH    4

// multiplier latency, issue to bus
`define OOO_MUL_STAGES  3
`define OOO_IMM_W       12

// derived index widths
`define OOO_ARCH_W      $clog2(`OOO_ARCH_REGS)
`define OOO_TAG_W       $clog2(`OOO_PHYS_REGS)
`define OOO_ROB_W       $clog2(`OOO_ROB_DEPTH)
`define OOO_RS_W        $clog2(`OOO_RS_DEPTH)

`endif

// File: hdl/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

  // basic index and data types
  typedef logic [`OOO_XLEN-1:0]   data_t;
  typedef logic [`OOO_ARCH_W-1:0] arch_idx_t;
  typedef logic [`OOO_TAG_W-1:0]  tag_t;
  typedef logic [`OOO_ROB_W-1:0]  rob_idx_t;

  // pre-decoded operations
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    XOR  = 3'd3,
    MUL  = 3'd4,
    ADDI = 3'd5
  } opcode_e;

  //////////////////////////////////////////////////
  // instruction word, two views of the same 21 bits
  //////////////////////////////////////////////////

  typedef struct packed {
    opcode_e                           opcode;
    arch_idx_t                         rd;
    arch_idx_t                         ra;
    arch_idx_t                         rb;
    logic [`OOO_IMM_W-`OOO_ARCH_W-1:0] pad;
  } reg_form_t;

  typedef struct packed {
    opcode_e               opcode;
    arch_idx_t             rd;
    arch_idx_t             ra;
    logic [`OOO_IMM_W-1:0] imm;
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } inst_word_u;

  // renamed instruction waiting in the RS
  typedef struct packed {
    opcode_e  opcode;
    data_t    imm;
    tag_t     dest;
    tag_t     src_a;
    logic     src_a_ready;
    tag_t     src_b;
    logic     src_b_ready;
    rob_idx_t rob_idx;
  } rs_entry_t;

  // common data bus word
  typedef struct packed {
    logic     valid;
    tag_t     tag;
    rob_idx_t rob_idx;
    data_t    value;
  } cdb_t;

  // in-order retire word
  typedef struct packed {
    logic      valid;
    arch_idx_t rd;
    data_t     value;
  } retire_t;

endpackage

// File: hdl/rename_unit.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rename_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                dispatch,
  input  ooo_pkg::inst_word_u inst,
  input  ooo_pkg::cdb_t       cdb,
  input  ooo_pkg::tag_t       free_tag,
  input  logic                free_valid,
  output ooo_pkg::tag_t       src_a,
  output ooo_pkg::tag_t       src_b,
  output ooo_pkg::tag_t       dest,
  output ooo_pkg::tag_t       old_dest,
  output logic                src_a_ready,
  output logic                src_b_ready,
  output logic                has_free
);
  import ooo_pkg::*;

  localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
  localparam int FL_W     = $clog2(FL_DEPTH);

  // map table, tag plus ready per arch reg
  tag_t                      map_tag [`OOO_ARCH_REGS];
  logic [`OOO_ARCH_REGS-1:0] map_ready;

  // circular free list
  tag_t            fl_q [FL_DEPTH];
  logic [FL_W-1:0] fl_head;
  logic [FL_W-1:0] fl_tail;
  logic [FL_W:0]   fl_count;

  // source lookup, bus match counts as ready this cycle
  assign src_a       = map_tag[inst.reg_form.ra];
  assign src_b       = map_tag[inst.reg_form.rb];
  assign src_a_ready = map_ready[inst.reg_form.ra] | (cdb.valid && cdb.tag == src_a);
  assign src_b_ready = map_ready[inst.reg_form.rb] | (cdb.valid && cdb.tag == src_b);

  // new tag from free list head, previous mapping goes to the ROB
  assign dest     = fl_q[fl_head];
  assign old_dest = map_tag[inst.reg_form.rd];
  assign has_free = (fl_count != '0);

  //////////////////////////////////////////////////
  // map table
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, all ready
      for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
        map_tag[i]   <= tag_t'(i);
        map_ready[i] <= 1'b1;
      end
    end else begin
      for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
        if (cdb.valid && map_tag[i] == cdb.tag) begin
          map_ready[i] <= 1'b1;
        end
      end
      // new destination overrides any wakeup
      if (dispatch) begin
        map_tag[inst.reg_form.rd]   <= dest;
        map_ready[inst.reg_form.rd] <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // free list
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the arch range start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_q[i] <= tag_t'(`OOO_ARCH_REGS + i);
      end
      fl_head  <= '0;
      fl_tail  <= '0;
      fl_count <= (FL_W+1)'(FL_DEPTH);
    end else begin
      // push from retire
      if (free_valid) begin
        fl_q[fl_tail] <= free_tag;
        fl_tail       <= fl_tail + 1'b1;
      end
      // pop on dispatch
      if (dispatch) begin
        fl_head <= fl_head + 1'b1;
      end
      case ({free_valid, dispatch})
        2'b10:   fl_count <= fl_count + 1'b1;
        2'b01:   fl_count <= fl_count - 1'b1;
        default: fl_count <= fl_count;
      endcase
    end
  end

endmodule

// File: hdl/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reservation_station (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch,
  input  ooo_pkg::rs_entry_t entry,
  input  ooo_pkg::cdb_t      cdb,
  input  logic               alu_accept,
  output logic               has_space,
  output ooo_pkg::rs_entry_t alu_issue,
  output ooo_pkg::rs_entry_t mul_issue,
  output logic               alu_issue_valid,
  output logic               mul_issue_valid
);
  import ooo_pkg::*;

  localparam int N  = `OOO_RS_DEPTH;
  localparam int AW = `OOO_RS_W;

  rs_entry_t     ent [N];
  logic [N-1:0]  busy;
  // age is the number of busy entries younger than this one
  logic [AW-1:0] age [N];
  logic [AW-1:0] next_age [N];

  logic [N-1:0]  ready;
  logic [N-1:0]  is_mul;
  logic [AW-1:0] alu_sel;
  logic [AW-1:0] mul_sel;
  logic [AW-1:0] free_sel;
  logic          alu_take;
  logic          mul_take;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      ready[i]  = busy[i] & ent[i].src_a_ready & ent[i].src_b_ready;
      is_mul[i] = (ent[i].opcode == MUL);
    end
  end

  //////////////////////////////////////////////////
  // select, oldest ready per unit
  //////////////////////////////////////////////////

  always_comb begin
    alu_issue_valid = 1'b0;
    mul_issue_valid = 1'b0;
    alu_sel         = '0;
    mul_sel         = '0;
    for (int i = 0; i < N; i++) begin
      if (ready[i] && !is_mul[i] && (!alu_issue_valid || age[i] > age[alu_sel])) begin
        alu_issue_valid = 1'b1;
        alu_sel         = AW'(i);
      end
      if (ready[i] && is_mul[i] && (!mul_issue_valid || age[i] > age[mul_sel])) begin
        mul_issue_valid = 1'b1;
        mul_sel         = AW'(i);
      end
    end
  end

  assign alu_issue = ent[alu_sel];
  assign mul_issue = ent[mul_sel];
  // multiplier never refuses
  assign alu_take  = alu_issue_valid & alu_accept;
  assign mul_take  = mul_issue_valid;

  // lowest free slot
  always_comb begin
    has_space = 1'b0;
    free_sel  = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        has_space = 1'b1;
        free_sel  = AW'(i);
      end
    end
  end

  // +1 for the newcomer, -1 per younger entry leaving
  always_comb begin
    for (int i = 0; i < N; i++) begin
      next_age[i] = age[i];
      if (dispatch) next_age[i] = next_age[i] + 1'b1;
      if (alu_take && age[alu_sel] < age[i]) next_age[i] = next_age[i] - 1'b1;
      if (mul_take && age[mul_sel] < age[i]) next_age[i] = next_age[i] - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      for (int i = 0; i < N; i++) begin
        age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        age[i] <= next_age[i];
      end
      if (alu_take) busy[alu_sel] <= 1'b0;
      if (mul_take) busy[mul_sel] <= 1'b0;
      if (dispatch) begin
        busy[free_sel] <= 1'b1;
        age[free_sel]  <= '0;
      end
    end
  end

  // entry payload and tag wakeup
  always_ff @(posedge clock) begin
    for (int i = 0; i < N; i++) begin
      if (cdb.valid && ent[i].src_a == cdb.tag) ent[i].src_a_ready <= 1'b1;
      if (cdb.valid && ent[i].src_b == cdb.tag) ent[i].src_b_ready <= 1'b1;
    end
    if (dispatch) begin
      ent[free_sel] <= entry;
    end
  end

endmodule

// File: hdl/phys_regfile.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module phys_regfile (
  input  logic           clock,
  input  logic           reset,
  input  ooo_pkg::cdb_t  cdb,
  input  ooo_pkg::tag_t  rd_tag_a [2],
  input  ooo_pkg::tag_t  rd_tag_b [2],
  output ooo_pkg::data_t rd_val_a [2],
  output ooo_pkg::data_t rd_val_b [2]
);
  import ooo_pkg::*;

  data_t regs [`OOO_PHYS_REGS];

  // arch state starts at zero, so every phys reg does too
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cdb.valid) begin
      regs[cdb.tag] <= cdb.value;
    end
  end

  // port 0 alu, port 1 multiplier
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rd_val_a[p] = regs[rd_tag_a[p]];
      rd_val_b[p] = regs[rd_tag_b[p]];
    end
  end

endmodule

// File: hdl/exec_cluster.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module exec_cluster (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::rs_entry_t alu_issue,
  input  ooo_pkg::rs_entry_t mul_issue,
  input  logic               alu_issue_valid,
  input  logic               mul_issue_valid,
  input  ooo_pkg::data_t     alu_a,
  input  ooo_pkg::data_t     alu_b,
  input  ooo_pkg::data_t     mul_a,
  input  ooo_pkg::data_t     mul_b,
  output logic               alu_accept,
  output ooo_pkg::cdb_t      cdb
);
  import ooo_pkg::*;

  localparam int LAST = `OOO_MUL_STAGES - 1;

  cdb_t  alu_hold;
  cdb_t  mul_pipe [`OOO_MUL_STAGES];
  data_t alu_result;
  logic  alu_grant;

  //////////////////////////////////////////////////
  // single-cycle ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_issue.opcode)
      SUB:     alu_result = alu_a - alu_b;
      AND:     alu_result = alu_a & alu_b;
      XOR:     alu_result = alu_a ^ alu_b;
      // immediate already sign-extended at dispatch
      ADDI:    alu_result = alu_a + alu_issue.imm;
      default: alu_result = alu_a + alu_b;
    endcase
  end

  // held result loses to the multiplier
  assign alu_grant  = alu_hold.valid & ~mul_pipe[LAST].valid;
  assign alu_accept = ~alu_hold.valid | alu_grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_hold.valid <= 1'b0;
    end else if (alu_accept) begin
      // refill or drain after grant
      alu_hold.valid   <= alu_issue_valid;
      alu_hold.tag     <= alu_issue.dest;
      alu_hold.rob_idx <= alu_issue.rob_idx;
      alu_hold.value   <= alu_result;
    end
  end

  //////////////////////////////////////////////////
  // multiplier shift pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `OOO_MUL_STAGES; i++) begin
        mul_pipe[i].valid <= 1'b0;
      end
    end else begin
      mul_pipe[0].valid   <= mul_issue_valid;
      mul_pipe[0].tag     <= mul_issue.dest;
      mul_pipe[0].rob_idx <= mul_issue.rob_idx;
      // low half of the product only
      mul_pipe[0].value   <= mul_a * mul_b;
      for (int i = 1; i < `OOO_MUL_STAGES; i++) begin
        mul_pipe[i] <= mul_pipe[i-1];
      end
    end
  end

  // bus select, multiplier first so it never stalls
  always_comb begin
    if (mul_pipe[LAST].valid) begin
      cdb = mul_pipe[LAST];
    end else if (alu_hold.valid) begin
      cdb = alu_hold;
    end else begin
      cdb = '0;
    end
  end

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reorder_buffer (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch,
  input  ooo_pkg::arch_idx_t rd,
  input  ooo_pkg::tag_t      old_dest,
  input  ooo_pkg::cdb_t      cdb,
  output ooo_pkg::rob_idx_t  alloc_idx,
  output logic               has_space,
  output ooo_pkg::tag_t      free_tag,
  output logic               free_valid,
  output ooo_pkg::retire_t   retire
);
  import ooo_pkg::*;

  localparam int N = `OOO_ROB_DEPTH;

  // per-entry payload
  arch_idx_t rob_rd  [N];
  tag_t      rob_old [N];
  data_t     rob_val [N];
  logic [N-1:0] rob_done;

  rob_idx_t             head;
  rob_idx_t             tail;
  logic [`OOO_ROB_W:0]  count;
  logic                 retiring;

  assign alloc_idx = tail;
  assign has_space = (count != (`OOO_ROB_W+1)'(N));

  // head leaves once its result is in
  assign retiring   = (count != '0) && rob_done[head];
  assign free_valid = retiring;
  assign free_tag   = rob_old[head];

  always_comb begin
    retire.valid = retiring;
    retire.rd    = rob_rd[head];
    retire.value = rob_val[head];
  end

  //////////////////////////////////////////////////
  // pointers and done bits
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      rob_done <= '0;
    end else begin
      // completion by ROB index
      if (cdb.valid) rob_done[cdb.rob_idx] <= 1'b1;
      if (dispatch) begin
        rob_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (retiring) head <= head + 1'b1;
      case ({dispatch, retiring})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // allocation payload and captured result
  always_ff @(posedge clock) begin
    if (dispatch) begin
      rob_rd[tail]  <= rd;
      rob_old[tail] <= old_dest;
    end
    if (cdb.valid) rob_val[cdb.rob_idx] <= cdb.value;
  end

endmodule

// File: hdl/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core (
  input  logic                clock,
  input  logic                reset,
  input  logic                inst_valid,
  input  ooo_pkg::inst_word_u inst,
  output logic                inst_ready,
  output ooo_pkg::retire_t    retire
);
  import ooo_pkg::*;

  logic      dispatch;
  logic      has_free;
  logic      rs_space;
  logic      rob_space;
  logic      is_imm;
  tag_t      src_a;
  tag_t      src_b;
  tag_t      dest;
  tag_t      old_dest;
  logic      src_a_ready;
  logic      src_b_ready;
  tag_t      free_tag;
  logic      free_valid;
  rob_idx_t  alloc_idx;
  rs_entry_t entry;
  rs_entry_t alu_issue;
  rs_entry_t mul_issue;
  logic      alu_issue_valid;
  logic      mul_issue_valid;
  logic      alu_accept;
  cdb_t      cdb;
  tag_t      rd_tag_a [2];
  tag_t      rd_tag_b [2];
  data_t     rd_val_a [2];
  data_t     rd_val_b [2];

  //////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////

  // space in all three structures, independent of valid
  assign inst_ready = has_free & rs_space & rob_space;
  assign dispatch   = inst_valid & inst_ready;
  assign is_imm     = (inst.imm_form.opcode == ADDI);

  always_comb begin
    entry.opcode      = inst.reg_form.opcode;
    entry.imm         = {{(`OOO_XLEN-`OOO_IMM_W){inst.imm_form.imm[`OOO_IMM_W-1]}},
                         inst.imm_form.imm};
    entry.dest        = dest;
    entry.src_a       = src_a;
    entry.src_a_ready = src_a_ready;
    entry.src_b       = src_b;
    // immediate form has no second source
    entry.src_b_ready = src_b_ready | is_imm;
    entry.rob_idx     = alloc_idx;
  end

  rename_unit u_rename (
    .clock       (clock),
    .reset       (reset),
    .dispatch    (dispatch),
    .inst        (inst),
    .cdb         (cdb),
    .free_tag    (free_tag),
    .free_valid  (free_valid),
    .src_a       (src_a),
    .src_b       (src_b),
    .dest        (dest),
    .old_dest    (old_dest),
    .src_a_ready (src_a_ready),
    .src_b_ready (src_b_ready),
    .has_free    (has_free)
  );

  reservation_station u_rs (
    .clock           (clock),
    .reset           (reset),
    .dispatch        (dispatch),
    .entry           (entry),
    .cdb             (cdb),
    .alu_accept      (alu_accept),
    .has_space       (rs_space),
    .alu_issue       (alu_issue),
    .mul_issue       (mul_issue),
    .alu_issue_valid (alu_issue_valid),
    .mul_issue_valid (mul_issue_valid)
  );

  // operand read, port 0 alu and port 1 multiplier
  assign rd_tag_a[0] = alu_issue.src_a;
  assign rd_tag_b[0] = alu_issue.src_b;
  assign rd_tag_a[1] = mul_issue.src_a;
  assign rd_tag_b[1] = mul_issue.src_b;

  phys_regfile u_prf (
    .clock    (clock),
    .reset    (reset),
    .cdb      (cdb),
    .rd_tag_a (rd_tag_a),
    .rd_tag_b (rd_tag_b),
    .rd_val_a (rd_val_a),
    .rd_val_b (rd_val_b)
  );

  exec_cluster u_exec (
    .clock           (clock),
    .reset           (reset),
    .alu_issue       (alu_issue),
    .mul_issue       (mul_issue),
    .alu_issue_valid (alu_issue_valid),
    .mul_issue_valid (mul_issue_valid),
    .alu_a           (rd_val_a[0]),
    .alu_b           (rd_val_b[0]),
    .mul_a           (rd_val_a[1]),
    .mul_b           (rd_val_b[1]),
    .alu_accept      (alu_accept),
    .cdb             (cdb)
  );

  reorder_buffer u_rob (
    .clock      (clock),
    .reset      (reset),
    .dispatch   (dispatch),
    .rd         (inst.reg_form.rd),
    .old_dest   (old_dest),
    .cdb        (cdb),
    .alloc_idx  (alloc_idx),
    .has_space  (rob_space),
    .free_tag   (free_tag),
    .free_valid (free_valid),
    .retire     (retire)
  );

endmodule

// File: bench/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int NUM_XFERS   = 300;
  localparam int STALL_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;

  // expected retire word holds arch rd and value
  typedef struct packed {
    arch_idx_t rd;
    data_t     value;
  } expect_t;

  logic       clock;
  logic       reset;
  logic       inst_valid;
  inst_word_u inst;
  logic       inst_ready;
  retire_t    retire;

  logic [31:0] seed;
  data_t       arch_regs [`OOO_ARCH_REGS];
  expect_t     expected_q [$];
  expect_t     head_exp;
  int          xfer_count;
  int          retire_count;
  logic        saw_stall;

  ooo_core uut (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .retire     (retire)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // lcg whose upper bits are the useful ones
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic inst_word_u make_reg_word(opcode_e op, arch_idx_t rd, arch_idx_t ra,
                                               arch_idx_t rb);
    inst_word_u w;
    w.reg_form.opcode = op;
    w.reg_form.rd     = rd;
    w.reg_form.ra     = ra;
    w.reg_form.rb     = rb;
    w.reg_form.pad    = '0;
    return w;
  endfunction

  function automatic inst_word_u make_imm_word(arch_idx_t rd, arch_idx_t ra,
                                               logic [`OOO_IMM_W-1:0] imm);
    inst_word_u w;
    w.imm_form.opcode = ADDI;
    w.imm_form.rd     = rd;
    w.imm_form.ra     = ra;
    w.imm_form.imm    = imm;
    return w;
  endfunction

  function automatic inst_word_u random_word();
    logic [31:0] r_op;
    logic [31:0] r_reg;
    logic [31:0] r_imm;
    opcode_e     op;
    r_op  = next_rand();
    r_reg = next_rand();
    r_imm = next_rand();
    op    = opcode_e'(3'(r_op[31:16] % 16'd6));
    if (op == ADDI) begin
      return make_imm_word(r_reg[30:28], r_reg[27:25], r_imm[27:16]);
    end
    return make_reg_word(op, r_reg[30:28], r_reg[27:25], r_reg[24:22]);
  endfunction

  // in-order reference giving the value written to rd
  function automatic data_t model_exec(inst_word_u w);
    data_t a;
    data_t b;
    int    imm_val;
    a       = arch_regs[w.reg_form.ra];
    b       = arch_regs[w.reg_form.rb];
    // two's complement value of the 12-bit field
    imm_val = int'(w.imm_form.imm);
    if (w.imm_form.imm[`OOO_IMM_W-1]) imm_val = imm_val - (1 << `OOO_IMM_W);
    case (w.reg_form.opcode)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      XOR:     return a ^ b;
      MUL:     return a * b;
      default: return a + data_t'(imm_val);
    endcase
  endfunction

  // hold valid and word until taken
  task automatic send_word(input inst_word_u word);
    int   waited;
    logic taken;
    inst_valid = 1'b1;
    inst       = word;
    waited     = 0;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clock);
      taken = inst_ready;
      @(posedge clock);
      #2;
      waited++;
      if (!taken && waited > STALL_LIMIT) fail_run("dispatch never became ready");
    end
    inst_valid = 1'b0;
  endtask

  task automatic idle_cycle();
    inst_valid = 1'b0;
    @(posedge clock);
    #2;
  endtask

  //////////////////////////////////////////////////
  // monitor sampling mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clock) begin
    if (!reset) begin
      // transfer happens on the coming edge
      if (inst_valid && inst_ready) begin
        arch_regs[inst.reg_form.rd] = model_exec(inst);
        expected_q.push_back({inst.reg_form.rd, arch_regs[inst.reg_form.rd]});
        xfer_count++;
      end
      if (!inst_ready) saw_stall = 1'b1;
      if (retire.valid) begin
        assert (expected_q.size() > 0)
          else fail_run("retire seen with no instruction outstanding");
        head_exp = expected_q.pop_front();
        assert (retire.rd == head_exp.rd && retire.value == head_exp.value)
          else fail_run($sformatf(
            "mismatch at %0t: retire rd %0d value %h, expected rd %0d value %h",
            $time, retire.rd, retire.value, head_exp.rd, head_exp.value));
        retire_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    int          drain_wait;
    seed         = 32'hbf7c;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    xfer_count   = 0;
    retire_count = 0;
    saw_stall    = 1'b0;
    for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
      arch_regs[i] = '0;
    end

    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;

    // idle state out of reset
    @(negedge clock);
    assert (!retire.valid) else fail_run("retire valid right after reset");
    assert (inst_ready) else fail_run("inst_ready low right after reset");
    @(posedge clock);
    #2;

    // negative and edge immediates
    send_word(make_imm_word(3'd1, 3'd0, 12'hffb));
    send_word(make_imm_word(3'd2, 3'd0, 12'h800));
    send_word(make_imm_word(3'd3, 3'd1, 12'h7ff));
    send_word(make_imm_word(3'd1, 3'd1, 12'hfff));

    // mul chain with dependent alu work behind it
    send_word(make_reg_word(MUL, 3'd4, 3'd1, 3'd3));
    send_word(make_reg_word(MUL, 3'd5, 3'd4, 3'd2));
    send_word(make_reg_word(ADD, 3'd6, 3'd5, 3'd3));
    send_word(make_reg_word(SUB, 3'd7, 3'd6, 3'd4));
    send_word(make_reg_word(XOR, 3'd0, 3'd7, 3'd5));
    send_word(make_reg_word(AND, 3'd6, 3'd0, 3'd2));

    // dependent mul burst that fills the RS
    for (int i = 0; i < 8; i++) begin
      send_word(make_reg_word(MUL, 3'd4, 3'd4, 3'd3));
    end
    send_word(make_reg_word(ADD, 3'd5, 3'd4, 3'd1));
    assert (saw_stall) else fail_run("inst_ready never dropped during the mul burst");

    // random mix with valid offered about three cycles in four
    while (xfer_count < NUM_XFERS) begin
      r = next_rand();
      if (r[29:28] == 2'b00) begin
        idle_cycle();
      end else begin
        send_word(random_word());
      end
    end

    // every transfer has to come back out as one retire
    drain_wait = 0;
    while (retire_count < xfer_count) begin
      idle_cycle();
      drain_wait++;
      if (drain_wait > DRAIN_LIMIT) fail_run("instructions left unretired after the drain");
    end
    // extra cycles catch duplicate retires
    repeat (20) idle_cycle();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: ooo_core.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/rename_unit.sv
hdl/reservation_station.sv
hdl/phys_regfile.sv
hdl/exec_cluster.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/ooo_core_tb.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := ooo_core_tb
FILELIST  := ooo_core.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) hdl/ooo_consts.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
